// ==== verilog.f ====
patch_pkg.sv
seq_ctrl_if.sv
sync_fifo.sv
msg_router.sv
dram_sequencer.sv
pixel_tracker.sv
apb_regs.sv
app_top.sv
tb_app_top.sv

// ==== Bender.yml ====
package:
  name: app_top

sources:
  - patch_pkg.sv
  - seq_ctrl_if.sv
  - sync_fifo.sv
  - msg_router.sv
  - dram_sequencer.sv
  - pixel_tracker.sv
  - apb_regs.sv
  - app_top.sv
  - target: test
    files:
      - tb_app_top.sv

// ==== tb_app_top.sv ====
`timescale 1ns/100ps

module tb_app_top import patch_pkg::*; ();
  localparam int N_BURST    = 4;
  localparam int N_DRAM_MSG = N_BURST * MSGS_PER_BURST;
  localparam int N_RD       = N_BURST - 1;    // reads per pass from burst 1 up
  localparam int N_PIX_MSG  = 29;
  localparam int N_BEATS    = 4 * 2 * N_RD;   // first pass plus three frames
  localparam int MAX_CYCLES = (N_DRAM_MSG + N_PIX_MSG + N_BEATS) * 60;
  localparam logic [ADDR_W-1:0] START = 27'd8;

  logic                  CLK, fds_val;
  logic                  pc_msg_pending, pc_msg_ack;
  logic [MSG_W-1:0]      pc_msg;
  logic                  app_en, dram_read, app_wdf_wren, app_wdf_end;
  logic                  app_rdy           = 1'b0;
  logic                  app_wdf_rdy       = 1'b0;
  logic                  app_rd_data_valid = 1'b0;
  logic [ADDR_W-1:0]     app_addr;
  logic [APP_DATA_W-1:0] app_wdf_data;
  logic [APP_DATA_W-1:0] app_rd_data       = '0;
  logic                  psel, penable, pwrite, pready, pslverr, error;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata, prdata;

  integer           seed;
  int               errors, cycles, pops, beats_rx, tb_level;
  int               wr_cmds, wr_beats, rd_cmds;
  logic [ADDR_W-1:0] wr_addr;
  logic [MSG_W-1:0] msgs [N_DRAM_MSG];
  logic [63:0]      mem_lo [16];
  logic [63:0]      mem_hi [16];
  logic [63:0]      rdq [$];
  logic             hi_read;
  pix_state_e       exp_pst;
  logic [FRAME_W-1:0] exp_frame;
  logic [ROW_W-1:0] exp_row;
  logic [COL_W-1:0] exp_col;

  app_top i_app_top (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] burst_beat(int b, bit hi);
    return hi ? {msgs[4*b+3], msgs[4*b+2]} : {msgs[4*b+1], msgs[4*b]};
  endfunction

  // memory controller model that checks write beats against the host bursts
  always @(posedge CLK) begin
    if (fds_val) begin
      app_rdy           <= 1'b0;
      app_wdf_rdy       <= 1'b0;
      app_rd_data_valid <= 1'b0;
      app_rd_data       <= '0;
    end else begin
      if (app_en && app_rdy && app_wdf_rdy && !dram_read) begin
        check_eq(app_addr, wr_cmds * ADDR_INC, "write address");
        wr_addr = app_addr;
        wr_cmds++;
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        check_eq(app_wdf_data, burst_beat(wr_beats / 2, wr_beats % 2), "write beat");
        check_eq(app_wdf_end, wr_beats % 2, "app_wdf_end");
        if (wr_beats % 2) mem_hi[wr_addr >> 3] = app_wdf_data;
        else mem_lo[wr_addr >> 3] = app_wdf_data;
        wr_beats++;
      end
      if (app_en && app_rdy && dram_read) begin
        check_eq(app_addr, START + ADDR_INC * (rd_cmds % N_RD), "read address");
        rdq.push_back(mem_lo[app_addr >> 3]);
        rdq.push_back(mem_hi[app_addr >> 3]);
        rd_cmds++;
      end
      // random read latency
      if (rdq.size() > 0 && ($random(seed) & 3) != 0) begin
        app_rd_data_valid <= 1'b1;
        app_rd_data       <= rdq.pop_front();
      end else app_rd_data_valid <= 1'b0;
      app_rdy     <= $random(seed);
      app_wdf_rdy <= app_wdf_wren ? 1'b1 : 1'($random(seed)); // no stall on the high beat
    end
  end

  assign hi_read = psel && penable && !pwrite && paddr == reg_coeff_hi;

  // coefficient fifo fill as seen from outside
  always @(posedge CLK) begin
    if (fds_val) begin
      tb_level <= 0;
      beats_rx <= 0;
    end else begin
      tb_level <= tb_level + int'(app_rd_data_valid) - int'(hi_read && tb_level != 0);
      beats_rx <= beats_rx + int'(app_rd_data_valid);
    end
  end

  a_pready: assert property (@(posedge CLK) pready) else begin
    errors++;
    $display("pready went low at %0t", $time);
  end
  a_ack_pending: assert property (@(posedge CLK) disable iff (fds_val)
    pc_msg_ack |-> pc_msg_pending) else begin
    errors++;
    $display("pc_msg_ack raised without a pending message at %0t", $time);
  end
  a_no_error: assert property (@(posedge CLK) disable iff (fds_val) !error) else begin
    errors++;
    $display("error output raised at %0t", $time);
  end
  a_level: assert property (@(posedge CLK) disable iff (fds_val) tb_level <= COEFF_DEPTH)
    else begin
      errors++;
      $display("coefficient fifo overfilled at %0t", $time);
    end
  a_throttle: assert property (@(posedge CLK) disable iff (fds_val)
    (tb_level >= COEFF_HIGH) [*3] |-> !(app_en && $past(app_en))) else begin
    errors++;
    $display("reads kept going above the throttle level at %0t", $time);
  end

  task automatic apb_write(input logic [APB_ADDR_W-1:0] a, input logic [APB_DATA_W-1:0] d);
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] a, output logic [APB_DATA_W-1:0] d,
                          output logic err);
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK); // access phase
    d   = prdata;
    err = pslverr;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_msg(input logic [MSG_W-1:0] m);
    @(posedge CLK);
    pc_msg_pending <= 1'b1;
    pc_msg         <= m;
    @(negedge CLK);
    while (!pc_msg_ack) @(negedge CLK);
    @(posedge CLK);
    pc_msg_pending <= 1'b0;
  endtask

  task automatic wait_beats(input int n);
    while (beats_rx < n) @(posedge CLK);
  endtask

  task automatic pop_beat();
    logic [APB_DATA_W-1:0] lo, hi;
    logic                  err;
    int                    p;
    p = pops % (2 * N_RD);
    @(negedge CLK);
    while (tb_level == 0) @(negedge CLK);
    apb_read(reg_coeff_lo, lo, err);
    apb_read(reg_coeff_hi, hi, err);
    check_eq({hi, lo}, burst_beat(START / ADDR_INC + p / 2, p % 2), "popped coefficient");
    pops++;
  endtask

  // tracker rule applied to one pixel message
  task automatic model_pix(input bit f, input bit l);
    case (exp_pst)
      pix_standby:
        if (!f) begin
          exp_frame = '0;
          exp_row   = '0;
          exp_col   = '0;
          exp_pst   = pix_interframe;
        end
      pix_interframe:
        if (l) begin
          exp_row = '0;
          exp_col = '0;
          exp_pst = pix_intraline;
        end
      pix_intraline:
        if (l) exp_col = exp_col + PIX_PER_CLK;
        else if (f) begin
          exp_row = exp_row + 1'b1;
          exp_pst = pix_interline;
        end else begin
          exp_frame = exp_frame + 1'b1;
          exp_pst   = pix_interframe;
        end
      pix_interline:
        if (l) begin
          exp_col = '0;
          exp_pst = pix_intraline;
        end
      default: exp_pst = pix_error;
    endcase
  endtask

  task automatic send_pix(input bit f, input bit l);
    logic [MSG_W-1:0]      m;
    logic [APB_DATA_W-1:0] d, exp_pos;
    logic                  err;
    m           = $random(seed);
    m[FVAL_BIT] = f;
    m[LVAL_BIT] = l;
    m[1:0]      = 2'b00;
    send_msg(m);
    model_pix(f, l);
    repeat (3) @(posedge CLK); // router, fifo, tracker
    apb_read(reg_frame, d, err);
    check_eq(d, exp_frame, "reg_frame");
    exp_pos              = '0;
    exp_pos[16 +: ROW_W] = exp_row;
    exp_pos[0 +: COL_W]  = exp_col;
    apb_read(reg_pos, d, err);
    check_eq(d, exp_pos, "reg_pos");
    apb_read(reg_status, d, err);
    check_eq(d[6:4], exp_pst, "tracker state");
  endtask

  task automatic send_frame(input int l0, input int l1, input int l2);
    int lens [3];
    lens = '{l0, l1, l2};
    for (int i = 0; i < 3; i++) begin
      repeat (lens[i]) send_pix(1'b1, 1'b1);
      send_pix(i < 2, 1'b0); // line gap or frame end after the last line
    end
  endtask

  initial begin
    logic [APB_DATA_W-1:0] d;
    logic                  err;
    seed              = 32'h7950_60a3;
    fds_val           = 1'b1;
    pc_msg_pending    = 1'b0;
    pc_msg            = '0;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    paddr             = '0;
    pwdata            = '0;
    exp_pst           = pix_standby;
    exp_frame         = '0;
    exp_row           = '0;
    exp_col           = '0;
    for (int i = 0; i < N_DRAM_MSG; i++) msgs[i] = $random(seed);
    for (int b = 0; b < N_BURST; b++)
      msgs[4*b][1:0] = (b == N_BURST - 1) ? 2'b01 : 2'b10; // last burst carries the marker
    repeat (10) @(posedge CLK);
    fds_val <= 1'b0;

    @(negedge CLK);
    check_eq(error, 1'b0, "error after reset");
    check_eq(app_en, 1'b0, "app_en after reset");
    check_eq(app_wdf_wren, 1'b0, "app_wdf_wren after reset");
    check_eq(dram_read, 1'b0, "dram_read after reset");
    check_eq(app_wdf_end, 1'b1, "app_wdf_end after reset");
    apb_read(reg_status, d, err);
    check_eq(d[2:0], seq_msg_wait, "sequencer state after reset");
    check_eq(d[6:4], pix_standby, "tracker state after reset");

    apb_write(reg_ctrl, START);
    apb_read(reg_ctrl, d, err);
    check_eq(d, START, "reg_ctrl readback");
    check_eq(err, 1'b0, "pslverr on reg_ctrl");
    apb_read(8'h1C, d, err);
    check_eq(err, 1'b1, "pslverr on unmapped offset");
    check_eq(d, 0, "prdata on unmapped offset");

    for (int i = 0; i < N_DRAM_MSG; i++) send_msg(msgs[i]);
    wait_beats(2 * N_RD);
    apb_read(reg_end_addr, d, err);
    check_eq(d, ADDR_INC * (N_BURST - 1), "reg_end_addr");
    repeat (2 * N_RD) pop_beat();

    send_pix(1'b0, 1'b0);
    send_frame(3, 5, 2);
    wait_beats(4 * N_RD);
    send_frame(4, 1, 6);
    wait_beats(6 * N_RD);
    send_pix(1'b1, 1'b1); // third frame start with a full fifo
    repeat (20) @(posedge CLK);
    apb_read(reg_status, d, err);
    check_eq(d[2:0], seq_throttled, "sequencer state with full fifo");
    while (pops < N_BEATS) pop_beat();
    repeat (4) @(posedge CLK);
    apb_read(reg_status, d, err);
    check_eq(d[2:0], seq_interframe, "sequencer state after last pass");

    $display("errors %0d, beats read %0d, beats popped %0d", errors, beats_rx, pops);
    if (errors == 0) $display("sim passed");
    else $display("sim failed");
    $finish;
  end

endmodule

// ==== app_top.sv ====
`timescale 1ns/100ps

module app_top import patch_pkg::*; (
  input  logic                  CLK,
  input  logic                  fds_val,
  input  logic                  pc_msg_pending,
  output logic                  pc_msg_ack,
  input  logic [MSG_W-1:0]      pc_msg,
  input  logic                  app_rdy,
  output logic                  app_en,
  output logic                  dram_read,
  output logic [ADDR_W-1:0]     app_addr,
  input  logic                  app_wdf_rdy,
  output logic                  app_wdf_wren,
  output logic                  app_wdf_end,
  output logic [APP_DATA_W-1:0] app_wdf_data,
  input  logic                  app_rd_data_valid,
  input  logic [APP_DATA_W-1:0] app_rd_data,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  error
);
  logic [MSG_W-1:0]   msg_word, pix_dout, dram_dout;
  logic               pix_wr, dram_wr, pix_high, dram_high;
  logic               pix_empty, pix_pop, pix_ovf, dram_empty, dram_pop;
  logic               frame_start, seq_err, pix_err;
  logic [FRAME_W-1:0] frame_count;
  logic [ROW_W-1:0]   row;
  logic [COL_W-1:0]   col;
  pix_state_e         pix_state;

  seq_ctrl_if ctrl_if ();

  assign error = seq_err || pix_err;

  // high sits one below depth to cover the registered write
  sync_fifo #(.WIDTH(MSG_W), .DEPTH(MSG_FIFO_DEPTH), .HIGH(MSG_FIFO_DEPTH-1)) i_pix_fifo (
    .CLK(CLK), .fds_val(fds_val), .wr_en(pix_wr), .din(msg_word),
    .rd_en(pix_pop), .dout(pix_dout), .full(), .high(pix_high),
    .empty(pix_empty), .overflow(pix_ovf), .level());

  sync_fifo #(.WIDTH(MSG_W), .DEPTH(MSG_FIFO_DEPTH), .HIGH(MSG_FIFO_DEPTH-1)) i_dram_fifo (
    .CLK(CLK), .fds_val(fds_val), .wr_en(dram_wr), .din(msg_word),
    .rd_en(dram_pop), .dout(dram_dout), .full(), .high(dram_high),
    .empty(dram_empty), .overflow(), .level());

  msg_router i_msg_router (
    .CLK(CLK), .fds_val(fds_val), .pc_msg_pending(pc_msg_pending), .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack), .pix_full(pix_high), .dram_full(dram_high),
    .pix_wr(pix_wr), .dram_wr(dram_wr), .msg_out(msg_word));

  dram_sequencer i_dram_sequencer (
    .CLK(CLK), .fds_val(fds_val), .msg_empty(dram_empty), .msg_data(dram_dout),
    .msg_pop(dram_pop), .app_rdy(app_rdy), .app_en(app_en), .dram_read(dram_read),
    .app_addr(app_addr), .app_wdf_rdy(app_wdf_rdy), .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
    .frame_start(frame_start), .ctrl(ctrl_if.seq), .seq_err(seq_err));

  pixel_tracker i_pixel_tracker (
    .CLK(CLK), .fds_val(fds_val), .pix_empty(pix_empty), .pix_data(pix_dout),
    .pix_pop(pix_pop), .overflow(pix_ovf), .frame_start(frame_start),
    .frame_count(frame_count), .row(row), .col(col), .state(pix_state),
    .pix_err(pix_err));

  apb_regs i_apb_regs (
    .CLK(CLK), .fds_val(fds_val), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .ctrl(ctrl_if.regs), .pix_state(pix_state),
    .frame_count(frame_count), .row(row), .col(col));

endmodule

// ==== apb_regs.sv ====
`timescale 1ns/100ps

module apb_regs import patch_pkg::*; (
  input  logic                  CLK,
  input  logic                  fds_val,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  seq_ctrl_if.regs              ctrl,
  input  pix_state_e            pix_state,
  input  logic [FRAME_W-1:0]    frame_count,
  input  logic [ROW_W-1:0]      row,
  input  logic [COL_W-1:0]      col
);
  logic access;
  logic addr_ok;

  assign access = psel && penable;
  assign pready = 1'b1;  // no wait states

  // read mux, also flags unmapped offsets
  always_comb begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (reg_addr_e'(paddr))
      reg_ctrl:     prdata = APB_DATA_W'(ctrl.start_addr);
      reg_status: begin
        prdata[2:0]   = ctrl.state;
        prdata[6:4]   = pix_state;
        prdata[8 +: LEVEL_W] = ctrl.coeff_level;
      end
      reg_frame:    prdata = APB_DATA_W'(frame_count);
      reg_pos: begin
        prdata[16 +: ROW_W] = row;
        prdata[0 +: COL_W]  = col;
      end
      reg_end_addr: prdata = APB_DATA_W'(ctrl.end_addr);
      reg_coeff_lo: prdata = ctrl.coeff_data[0 +: APB_DATA_W];
      reg_coeff_hi: prdata = ctrl.coeff_data[APB_DATA_W +: APB_DATA_W];
      default:      addr_ok = 1'b0;
    endcase
  end

  assign pslverr = access && !addr_ok;

  // reading the high half retires the word, lo half must be read first
  assign ctrl.coeff_pop = access && !pwrite && paddr == reg_coeff_hi
                          && ctrl.coeff_level != '0;

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) ctrl.start_addr <= '0;
    else if (access && pwrite && paddr == reg_ctrl)
      ctrl.start_addr <= pwdata[ADDR_W-1:0];
  end

endmodule

// ==== pixel_tracker.sv ====
`timescale 1ns/100ps

module pixel_tracker import patch_pkg::*; (
  input  logic               CLK,
  input  logic               fds_val,
  input  logic               pix_empty,
  input  logic [MSG_W-1:0]   pix_data,
  output logic               pix_pop,
  input  logic               overflow,
  output logic               frame_start,
  output logic [FRAME_W-1:0] frame_count,
  output logic [ROW_W-1:0]   row,
  output logic [COL_W-1:0]   col,
  output pix_state_e         state,
  output logic               pix_err
);
  logic fval, lval;

  assign fval    = pix_data[FVAL_BIT];
  assign lval    = pix_data[LVAL_BIT];
  assign pix_pop = !pix_empty; // nothing downstream to wait for
  assign pix_err = state == pix_error;

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state       <= pix_standby;
      frame_start <= 1'b0;
      frame_count <= '0;
      row         <= '0;
      col         <= '0;
    end else begin
      frame_start <= 1'b0;
      if (overflow) state <= pix_error;
      else if (!pix_empty) begin
        case (state)
          pix_standby:
            if (!fval) begin // sync to a frame gap first
              frame_count <= '0;
              row         <= '0;
              col         <= '0;
              state       <= pix_interframe;
            end
          pix_interframe:
            if (lval) begin
              row         <= '0;
              col         <= '0;
              frame_start <= 1'b1;
              state       <= pix_intraline;
            end
          pix_intraline:
            if (lval) col <= col + PIX_PER_CLK;
            else if (fval) begin
              row   <= row + 1'b1;
              state <= pix_interline;
            end else begin
              frame_count <= frame_count + 1'b1;
              state       <= pix_interframe;
            end
          pix_interline:
            if (lval) begin
              col   <= '0;
              state <= pix_intraline;
            end
          default: state <= pix_error;
        endcase
      end
    end
  end

endmodule

// ==== dram_sequencer.sv ====
`timescale 1ns/100ps

module dram_sequencer import patch_pkg::*; (
  input  logic                  CLK,
  input  logic                  fds_val,
  input  logic                  msg_empty,
  input  logic [MSG_W-1:0]      msg_data,
  output logic                  msg_pop,
  input  logic                  app_rdy,
  output logic                  app_en,
  output logic                  dram_read,
  output logic [ADDR_W-1:0]     app_addr,
  input  logic                  app_wdf_rdy,
  output logic                  app_wdf_wren,
  output logic                  app_wdf_end,
  output logic [APP_DATA_W-1:0] app_wdf_data,
  input  logic                  app_rd_data_valid,
  input  logic [APP_DATA_W-1:0] app_rd_data,
  input  logic                  frame_start,
  seq_ctrl_if.seq               ctrl,
  output logic                  seq_err
);
  seq_state_e                          state;
  logic [ADDR_W-1:0]                   end_addr;
  logic [$clog2(MSGS_PER_BURST)-1:0]   msg_idx;
  logic [MSGS_PER_BURST*MSG_W-1:0]     burst_buf;  // low message first
  logic                                coeff_high, coeff_ovf;

  sync_fifo #(
    .WIDTH(APP_DATA_W), .DEPTH(COEFF_DEPTH), .HIGH(COEFF_HIGH)
  ) i_coeff_fifo (
    .CLK(CLK), .fds_val(fds_val),
    .wr_en(app_rd_data_valid), .din(app_rd_data),
    .rd_en(ctrl.coeff_pop), .dout(ctrl.coeff_data),
    .full(), .high(coeff_high), .empty(),
    .overflow(coeff_ovf), .level(ctrl.coeff_level)
  );

  assign msg_pop       = state == seq_msg_wait && !msg_empty;
  assign seq_err       = state == seq_error;
  assign ctrl.state    = state;
  assign ctrl.end_addr = end_addr;

  // burst payload and write beats
  always_ff @(posedge CLK) begin
    if (msg_pop) burst_buf[msg_idx*MSG_W +: MSG_W] <= msg_data;
    if (state == seq_wr_wait && app_rdy && app_wdf_rdy)
      app_wdf_data <= burst_buf[0 +: APP_DATA_W];
    else if (state == seq_wr1 && app_wdf_rdy)
      app_wdf_data <= burst_buf[APP_DATA_W +: APP_DATA_W];
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state        <= seq_msg_wait;
      app_en       <= 1'b0;
      dram_read    <= 1'b0;
      app_addr     <= '0;
      end_addr     <= '0;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1;
      msg_idx      <= '0;
    end else begin
      case (state)
        seq_msg_wait:
          if (!msg_empty) begin
            msg_idx <= msg_idx + 1'b1;
            if (msg_idx == MSGS_PER_BURST - 1) begin
              app_en <= 1'b1; // write command
              state  <= seq_wr_wait;
            end
          end
        seq_wr_wait:
          if (app_rdy && app_wdf_rdy) begin
            app_en       <= 1'b0;
            app_addr     <= app_addr + ADDR_INC;
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            state        <= seq_wr1;
          end
        seq_wr1:
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;
            state       <= seq_wr2;
          end
        seq_wr2: begin
          app_wdf_wren <= 1'b0;
          if (!app_wdf_rdy) state <= seq_error;  // high beat stalled
          else if (burst_buf[1:0] == 2'b01) begin // end-of-coefficients marker
            end_addr  <= app_addr - ADDR_INC;
            app_addr  <= ctrl.start_addr;
            dram_read <= 1'b1;
            app_en    <= 1'b1;
            state     <= seq_reading;
          end else state <= seq_msg_wait;
        end
        seq_reading:
          if (coeff_ovf) begin
            app_en <= 1'b0;
            state  <= seq_error;
          end else if (app_rdy && app_addr == end_addr) begin
            app_en <= 1'b0;
            state  <= seq_interframe;
          end else begin
            if (app_rdy) app_addr <= app_addr + ADDR_INC;
            if (coeff_high) begin
              app_en <= 1'b0;
              state  <= seq_throttled;
            end
          end
        seq_throttled:
          if (coeff_ovf) state <= seq_error;
          else if (!coeff_high) begin
            app_en <= 1'b1;
            state  <= seq_reading;
          end
        seq_interframe:
          if (coeff_ovf) state <= seq_error;
          else if (frame_start) begin // loop the region for the new frame
            app_addr <= ctrl.start_addr;
            app_en   <= 1'b1;
            state    <= seq_reading;
          end
        default: app_en <= 1'b0;  // seq_error holds
      endcase
    end
  end

  a_wren_in_write: assert property (@(posedge CLK) disable iff (fds_val)
    app_wdf_wren |-> state inside {seq_wr1, seq_wr2});

endmodule

// ==== msg_router.sv ====
`timescale 1ns/100ps

module msg_router import patch_pkg::*; (
  input  logic             CLK,
  input  logic             fds_val,
  input  logic             pc_msg_pending,
  input  logic [MSG_W-1:0] pc_msg,
  output logic             pc_msg_ack,
  input  logic             pix_full,
  input  logic             dram_full,
  output logic             pix_wr,
  output logic             dram_wr,
  output logic [MSG_W-1:0] msg_out
);
  logic [$clog2(MSGS_PER_BURST)-1:0] burst_cnt;
  logic                              is_pix;

  // only the head of a burst can be a pixel message
  assign is_pix     = burst_cnt == 0 && pc_msg[1:0] == 2'b00;
  assign pc_msg_ack = pc_msg_pending && !pix_full && !dram_full;

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      pix_wr    <= 1'b0;
      dram_wr   <= 1'b0;
      burst_cnt <= '0;
    end else begin
      pix_wr  <= pc_msg_ack && is_pix;
      dram_wr <= pc_msg_ack && !is_pix;
      if (pc_msg_ack && !is_pix)
        burst_cnt <= (burst_cnt == MSGS_PER_BURST - 1) ? '0 : burst_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (pc_msg_ack) msg_out <= pc_msg; // lines up with the write enables
  end

  a_one_dest: assert property (@(posedge CLK) disable iff (fds_val) !(pix_wr && dram_wr));

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8,
  parameter int HIGH  = 6
) (
  input  logic                       CLK,
  input  logic                       fds_val,
  input  logic                       wr_en,
  input  logic [WIDTH-1:0]           din,
  input  logic                       rd_en,
  output logic [WIDTH-1:0]           dout,
  output logic                       full,
  output logic                       high,
  output logic                       empty,
  output logic                       overflow,
  output logic [$clog2(DEPTH+1)-1:0] level
);
  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
  logic                       do_wr, do_rd;

  assign do_wr = wr_en && !full;   // writes into a full fifo are dropped
  assign do_rd = rd_en && !empty;

  assign dout  = mem[rd_ptr];      // first word falls through
  assign full  = level == DEPTH;
  assign high  = level >= HIGH;
  assign empty = level == 0;

  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      level <= level + do_wr - do_rd;
      if (wr_en && full) overflow <= 1'b1; // sticky until reset
    end
  end

  // consumers look at empty or level before popping
  a_no_read_empty: assert property (@(posedge CLK) disable iff (fds_val) rd_en |-> !empty);

endmodule

// ==== seq_ctrl_if.sv ====
`timescale 1ns/100ps

interface seq_ctrl_if import patch_pkg::*; ();
  logic [ADDR_W-1:0]     start_addr;  // read-back base
  logic                  coeff_pop;
  seq_state_e            state;
  logic [ADDR_W-1:0]     end_addr;    // last coefficient burst
  logic [APP_DATA_W-1:0] coeff_data;  // head of coefficient fifo
  logic [LEVEL_W-1:0]    coeff_level;

  modport regs (
    output start_addr, coeff_pop,
    input  state, end_addr, coeff_data, coeff_level
  );

  modport seq (
    input  start_addr, coeff_pop,
    output state, end_addr, coeff_data, coeff_level
  );
endinterface

// ==== patch_pkg.sv ====
package patch_pkg;

  // host stream and memory port
  localparam int MSG_W          = 32;
  localparam int APP_DATA_W     = 64;
  localparam int ADDR_W         = 27;
  localparam logic [ADDR_W-1:0] ADDR_INC = 27'd8; // BL8, one burst per step
  localparam int MSGS_PER_BURST = 4;

  // fifo sizing
  localparam int COEFF_DEPTH    = 16;
  localparam int COEFF_HIGH     = 12; // read throttle point
  localparam int MSG_FIFO_DEPTH = 8;
  localparam int LEVEL_W        = $clog2(COEFF_DEPTH + 1);

  // pixel message fields and counters
  localparam int FVAL_BIT = 5;
  localparam int LVAL_BIT = 4;
  localparam int ROW_W    = 12;
  localparam int COL_W    = 11;
  localparam int FRAME_W  = 16;
  localparam logic [COL_W-1:0] PIX_PER_CLK = 11'd2;

  // apb bus
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef enum logic [2:0] {
    seq_error, seq_msg_wait, seq_wr_wait, seq_wr1, seq_wr2,
    seq_reading, seq_throttled, seq_interframe
  } seq_state_e;

  typedef enum logic [2:0] {
    pix_error, pix_standby, pix_intraline, pix_interline, pix_interframe
  } pix_state_e;

  // byte offsets
  typedef enum logic [APB_ADDR_W-1:0] {
    reg_ctrl     = 8'h00,
    reg_status   = 8'h04,
    reg_frame    = 8'h08,
    reg_pos      = 8'h0C,
    reg_end_addr = 8'h10,
    reg_coeff_lo = 8'h14,
    reg_coeff_hi = 8'h18
  } reg_addr_e;

endpackage
